/* design/cmd_pkg.sv */
package cmd_pkg;

	//////////////////////////////
	// command field widths
	//////////////////////////////

	parameter int ADDR_WIDTH = 32;
	parameter int DATA_WIDTH = 64;
	parameter int TAG_WIDTH = 16;

	// tag below the unit id bit
	parameter int INDEX_WIDTH = TAG_WIDTH - 1;

	typedef enum logic {
		READ_CL,
		WRITE_MI
	} cmd_opcode_t;

	// upper tag bit, selects the read data owner
	typedef enum logic {
		VERTEX_CONTROL_ID,
		ALGORITHM_CONTROL_ID
	} cu_id_t;

	// buffered command is {opcode, addr, tag}
	parameter int CMD_WIDTH = $bits(cmd_opcode_t) + ADDR_WIDTH + TAG_WIDTH;

endpackage

/* design/command_arbiter.sv */
module command_arbiter import cmd_pkg::*; (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  logic [1:0]            requests,
	input  cmd_opcode_t           cmd_in_0_opcode,
	input  logic [ADDR_WIDTH-1:0] cmd_in_0_addr,
	input  logic [TAG_WIDTH-1:0]  cmd_in_0_tag,
	input  cmd_opcode_t           cmd_in_1_opcode,
	input  logic [ADDR_WIDTH-1:0] cmd_in_1_addr,
	input  logic [TAG_WIDTH-1:0]  cmd_in_1_tag,
	output logic [1:0]            ready,
	output logic                  cmd_out_valid,
	output cmd_opcode_t           cmd_out_opcode,
	output logic [ADDR_WIDTH-1:0] cmd_out_addr,
	output logic [TAG_WIDTH-1:0]  cmd_out_tag
);

	logic [1:0] grant;
	// set when buffer 1 won last
	logic last_winner;

	always_comb begin
		grant = 2'b00;
		if (enabled) begin
			case (requests)
				2'b01: grant = 2'b01;
				2'b10: grant = 2'b10;
				// both active, the other one gets its turn
				2'b11: grant = last_winner ? 2'b01 : 2'b10;
				default: grant = 2'b00;
			endcase
		end
	end

	// pop strobe to the granted buffer
	assign ready = grant;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_out_valid <= 1'b0;
			last_winner <= 1'b0;
		end else if (enabled) begin
			cmd_out_valid <= |grant;
			if (|grant) begin
				last_winner <= grant[1];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (grant[1]) begin
			cmd_out_opcode <= cmd_in_1_opcode;
			cmd_out_addr <= cmd_in_1_addr;
			cmd_out_tag <= cmd_in_1_tag;
		end else if (grant[0]) begin
			cmd_out_opcode <= cmd_in_0_opcode;
			cmd_out_addr <= cmd_in_0_addr;
			cmd_out_tag <= cmd_in_0_tag;
		end
	end

endmodule

/* design/cu_control.sv */
module cu_control import cmd_pkg::*, graph_pkg::*; #(
	parameter int VERTEX_QUEUE_DEPTH = 16,
	parameter int COMMAND_BUFFER_DEPTH = 8
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic                   start,
	input  logic [ADDR_WIDTH-1:0]  vertex_base,
	input  logic [ADDR_WIDTH-1:0]  edge_base,
	input  logic [ADDR_WIDTH-1:0]  result_base,
	input  logic [COUNT_WIDTH-1:0] num_vertices,
	input  logic [COUNT_WIDTH-1:0] num_edges,
	output logic                   read_cmd_valid,
	output cmd_opcode_t            read_cmd_opcode,
	output logic [ADDR_WIDTH-1:0]  read_cmd_addr,
	output logic [TAG_WIDTH-1:0]   read_cmd_tag,
	input  logic                   read_buffer_alfull,
	input  logic                   read_data_valid,
	input  logic [TAG_WIDTH-1:0]   read_data_tag,
	input  logic [DATA_WIDTH-1:0]  read_data,
	output logic                   write_cmd_valid,
	output logic [ADDR_WIDTH-1:0]  write_cmd_addr,
	output logic [DATA_WIDTH-1:0]  write_cmd_data,
	output logic [TAG_WIDTH-1:0]   write_cmd_tag,
	input  logic                   write_buffer_alfull,
	input  logic                   write_resp_valid,
	input  logic [TAG_WIDTH-1:0]   write_resp_tag,
	output logic [63:0]            algorithm_status
);

	// latched inputs
	logic start_q;
	logic [ADDR_WIDTH-1:0] vertex_base_q;
	logic [ADDR_WIDTH-1:0] edge_base_q;
	logic [ADDR_WIDTH-1:0] result_base_q;
	logic [COUNT_WIDTH-1:0] num_vertices_q;
	logic [COUNT_WIDTH-1:0] num_edges_q;
	logic read_buffer_alfull_q;
	logic read_data_valid_q;
	logic [TAG_WIDTH-1:0] read_data_tag_q;
	logic [DATA_WIDTH-1:0] read_data_q;
	logic write_buffer_alfull_q;
	logic write_resp_valid_q;
	logic [TAG_WIDTH-1:0] write_resp_tag_q;

	// routed read data
	logic vertex_data_valid;
	logic algorithm_data_valid;
	logic [TAG_WIDTH-1:0] routed_tag;
	logic [DATA_WIDTH-1:0] routed_data;
	logic algorithm_resp_valid;

	// unit commands and buffers
	logic vertex_cmd_valid;
	cmd_opcode_t vertex_cmd_opcode;
	logic [ADDR_WIDTH-1:0] vertex_cmd_addr;
	logic [TAG_WIDTH-1:0] vertex_cmd_tag;
	logic algorithm_cmd_valid;
	cmd_opcode_t algorithm_cmd_opcode;
	logic [ADDR_WIDTH-1:0] algorithm_cmd_addr;
	logic [TAG_WIDTH-1:0] algorithm_cmd_tag;
	logic [CMD_WIDTH-1:0] vertex_cmd_head;
	logic [CMD_WIDTH-1:0] algorithm_cmd_head;
	logic vertex_buffer_empty;
	logic vertex_buffer_alfull;
	logic algorithm_buffer_empty;
	logic algorithm_buffer_alfull;
	logic [1:0] requests;
	logic [1:0] ready;

	// arbiter output
	logic arb_valid;
	cmd_opcode_t arb_opcode;
	logic [ADDR_WIDTH-1:0] arb_addr;
	logic [TAG_WIDTH-1:0] arb_tag;

	// vertex jobs
	logic job_valid;
	logic job_pop;
	logic [COUNT_WIDTH-1:0] job_id;
	logic [COUNT_WIDTH-1:0] job_offset;
	logic [COUNT_WIDTH-1:0] job_degree;

	// algorithm write path
	logic gac_write_valid;
	logic [ADDR_WIDTH-1:0] gac_write_addr;
	logic [DATA_WIDTH-1:0] gac_write_data;
	logic [TAG_WIDTH-1:0] gac_write_tag;

	// completion
	logic [COUNT_WIDTH-1:0] vertices_filtered;
	logic [COUNT_WIDTH-1:0] vertices_done;
	logic [COUNT_WIDTH-1:0] edges_done;
	logic [COUNT_WIDTH-1:0] vertices_total;
	logic active;
	logic done;

	//////////////////////////////
	// input and output registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			start_q <= 1'b0;
			read_buffer_alfull_q <= 1'b0;
			read_data_valid_q <= 1'b0;
			write_buffer_alfull_q <= 1'b0;
			write_resp_valid_q <= 1'b0;
			vertex_data_valid <= 1'b0;
			algorithm_data_valid <= 1'b0;
			active <= 1'b0;
			read_cmd_valid <= 1'b0;
			write_cmd_valid <= 1'b0;
			algorithm_status <= '0;
		end else begin
			// status reads zero while disabled
			algorithm_status <= (enabled && done) ? {edges_done, vertices_total} : '0;
			if (enabled) begin
				start_q <= start;
				read_buffer_alfull_q <= read_buffer_alfull;
				read_data_valid_q <= read_data_valid;
				write_buffer_alfull_q <= write_buffer_alfull;
				write_resp_valid_q <= write_resp_valid;
				// route by the owner id in the tag
				vertex_data_valid <= read_data_valid_q &&
					(cu_id_t'(read_data_tag_q[TAG_WIDTH-1]) == VERTEX_CONTROL_ID);
				algorithm_data_valid <= read_data_valid_q &&
					(cu_id_t'(read_data_tag_q[TAG_WIDTH-1]) == ALGORITHM_CONTROL_ID);
				if (start_q) begin
					active <= 1'b1;
				end
				read_cmd_valid <= arb_valid;
				write_cmd_valid <= gac_write_valid;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			vertex_base_q <= vertex_base;
			edge_base_q <= edge_base;
			result_base_q <= result_base;
			num_vertices_q <= num_vertices;
			num_edges_q <= num_edges;
			read_data_tag_q <= read_data_tag;
			read_data_q <= read_data;
			write_resp_tag_q <= write_resp_tag;
			routed_tag <= read_data_tag_q;
			routed_data <= read_data_q;
			read_cmd_opcode <= arb_opcode;
			read_cmd_addr <= arb_addr;
			read_cmd_tag <= arb_tag;
			write_cmd_addr <= gac_write_addr;
			write_cmd_data <= gac_write_data;
			write_cmd_tag <= gac_write_tag;
		end
	end

	assign algorithm_resp_valid = write_resp_valid_q &&
		(cu_id_t'(write_resp_tag_q[TAG_WIDTH-1]) == ALGORITHM_CONTROL_ID);

	// filtered plus completed vertices, and all edges seen
	assign vertices_total = vertices_filtered + vertices_done;
	assign done = active && (vertices_total == num_vertices_q) && (edges_done == num_edges_q);

	//////////////////////////////
	// control units
	//////////////////////////////

	vertex_job_control #(
		.VERTEX_QUEUE_DEPTH(VERTEX_QUEUE_DEPTH)
	) vertex_job_control0 (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.start            (start_q),
		.vertex_base      (vertex_base_q),
		.num_vertices     (num_vertices_q),
		.buffer_alfull    (vertex_buffer_alfull),
		.read_data_valid  (vertex_data_valid),
		.read_data_tag    (routed_tag),
		.read_data        (routed_data),
		.cmd_valid        (vertex_cmd_valid),
		.cmd_opcode       (vertex_cmd_opcode),
		.cmd_addr         (vertex_cmd_addr),
		.cmd_tag          (vertex_cmd_tag),
		.job_pop          (job_pop),
		.job_valid        (job_valid),
		.job_id           (job_id),
		.job_offset       (job_offset),
		.job_degree       (job_degree),
		.vertices_filtered(vertices_filtered)
	);

	graph_algorithm_control graph_algorithm_control0 (
		.clock              (clock),
		.rstn               (rstn),
		.enabled            (enabled),
		.start              (start_q),
		.edge_base          (edge_base_q),
		.result_base        (result_base_q),
		.job_valid          (job_valid),
		.job_id             (job_id),
		.job_offset         (job_offset),
		.job_degree         (job_degree),
		.job_pop            (job_pop),
		.buffer_alfull      (algorithm_buffer_alfull),
		.read_data_valid    (algorithm_data_valid),
		.read_data_tag      (routed_tag),
		.read_data          (routed_data),
		.cmd_valid          (algorithm_cmd_valid),
		.cmd_opcode         (algorithm_cmd_opcode),
		.cmd_addr           (algorithm_cmd_addr),
		.cmd_tag            (algorithm_cmd_tag),
		.write_buffer_alfull(write_buffer_alfull_q),
		.write_cmd_valid    (gac_write_valid),
		.write_cmd_addr     (gac_write_addr),
		.write_cmd_data     (gac_write_data),
		.write_cmd_tag      (gac_write_tag),
		.write_resp_valid   (algorithm_resp_valid),
		.vertices_done      (vertices_done),
		.edges_done         (edges_done)
	);

	//////////////////////////////
	// read command buffers
	//////////////////////////////

	sync_fifo #(
		.WIDTH(CMD_WIDTH),
		.DEPTH(COMMAND_BUFFER_DEPTH)
	) vertex_cmd_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_cmd_valid && enabled),
		.data_in ({vertex_cmd_opcode, vertex_cmd_addr, vertex_cmd_tag}),
		.pop     (ready[0]),
		.data_out(vertex_cmd_head),
		.empty   (vertex_buffer_empty),
		.full    (),
		.alfull  (vertex_buffer_alfull)
	);

	sync_fifo #(
		.WIDTH(CMD_WIDTH),
		.DEPTH(COMMAND_BUFFER_DEPTH)
	) algorithm_cmd_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (algorithm_cmd_valid && enabled),
		.data_in ({algorithm_cmd_opcode, algorithm_cmd_addr, algorithm_cmd_tag}),
		.pop     (ready[1]),
		.data_out(algorithm_cmd_head),
		.empty   (algorithm_buffer_empty),
		.full    (),
		.alfull  (algorithm_buffer_alfull)
	);

	assign requests[0] = !vertex_buffer_empty && !read_buffer_alfull_q;
	assign requests[1] = !algorithm_buffer_empty && !read_buffer_alfull_q;

	command_arbiter command_arbiter0 (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.requests       (requests),
		.cmd_in_0_opcode(cmd_opcode_t'(vertex_cmd_head[CMD_WIDTH-1])),
		.cmd_in_0_addr  (vertex_cmd_head[TAG_WIDTH +: ADDR_WIDTH]),
		.cmd_in_0_tag   (vertex_cmd_head[TAG_WIDTH-1:0]),
		.cmd_in_1_opcode(cmd_opcode_t'(algorithm_cmd_head[CMD_WIDTH-1])),
		.cmd_in_1_addr  (algorithm_cmd_head[TAG_WIDTH +: ADDR_WIDTH]),
		.cmd_in_1_tag   (algorithm_cmd_head[TAG_WIDTH-1:0]),
		.ready          (ready),
		.cmd_out_valid  (arb_valid),
		.cmd_out_opcode (arb_opcode),
		.cmd_out_addr   (arb_addr),
		.cmd_out_tag    (arb_tag)
	);

endmodule

/* design/graph_algorithm_control.sv */
module graph_algorithm_control import cmd_pkg::*, graph_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic                   start,
	input  logic [ADDR_WIDTH-1:0]  edge_base,
	input  logic [ADDR_WIDTH-1:0]  result_base,
	input  logic                   job_valid,
	input  logic [COUNT_WIDTH-1:0] job_id,
	input  logic [COUNT_WIDTH-1:0] job_offset,
	input  logic [COUNT_WIDTH-1:0] job_degree,
	output logic                   job_pop,
	input  logic                   buffer_alfull,
	input  logic                   read_data_valid,
	input  logic [TAG_WIDTH-1:0]   read_data_tag,
	input  logic [DATA_WIDTH-1:0]  read_data,
	output logic                   cmd_valid,
	output cmd_opcode_t            cmd_opcode,
	output logic [ADDR_WIDTH-1:0]  cmd_addr,
	output logic [TAG_WIDTH-1:0]   cmd_tag,
	input  logic                   write_buffer_alfull,
	output logic                   write_cmd_valid,
	output logic [ADDR_WIDTH-1:0]  write_cmd_addr,
	output logic [DATA_WIDTH-1:0]  write_cmd_data,
	output logic [TAG_WIDTH-1:0]   write_cmd_tag,
	input  logic                   write_resp_valid,
	output logic [COUNT_WIDTH-1:0] vertices_done,
	output logic [COUNT_WIDTH-1:0] edges_done
);

	algorithm_state_t state;
	logic [COUNT_WIDTH-1:0] cur_id;
	logic [ADDR_WIDTH-1:0] edge_addr;
	logic [COUNT_WIDTH-1:0] issue_left;
	logic [COUNT_WIDTH-1:0] return_left;
	logic [INDEX_WIDTH-1:0] edge_seq;
	logic [DATA_WIDTH-1:0] sum;
	logic issue;
	logic write_go;

	assign job_pop = enabled && (state == A_IDLE) && job_valid;
	assign issue = enabled && (state == A_ISSUE) && (issue_left != '0) && !buffer_alfull;
	assign write_go = enabled && (state == A_WRITE) && !write_buffer_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= A_IDLE;
			cmd_valid <= 1'b0;
			write_cmd_valid <= 1'b0;
			issue_left <= '0;
			return_left <= '0;
			vertices_done <= '0;
			edges_done <= '0;
		end else if (enabled) begin
			cmd_valid <= issue;
			write_cmd_valid <= write_go;
			if (start) begin
				edges_done <= '0;
				vertices_done <= '0;
			end else begin
				edges_done <= edges_done + COUNT_WIDTH'(read_data_valid);
				vertices_done <= vertices_done + COUNT_WIDTH'(write_resp_valid);
			end
			if (read_data_valid) begin
				return_left <= return_left - 1'b1;
			end
			case (state)
				A_IDLE: begin
					if (job_valid) begin
						issue_left <= job_degree;
						return_left <= job_degree;
						state <= A_ISSUE;
					end
				end
				A_ISSUE: begin
					if (issue) begin
						issue_left <= issue_left - 1'b1;
					end else if (issue_left == '0) begin
						state <= A_COLLECT;
					end
				end
				// edges may return in any order
				A_COLLECT: if (return_left == '0) state <= A_WRITE;
				A_WRITE: if (!write_buffer_alfull) state <= A_IDLE;
				default: state <= A_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (job_pop) begin
			cur_id <= job_id;
			edge_addr <= edge_base + ADDR_WIDTH'(job_offset * WORD_BYTES);
			edge_seq <= '0;
			sum <= '0;
		end
		if (issue) begin
			cmd_opcode <= READ_CL;
			cmd_addr <= edge_addr;
			cmd_tag <= {ALGORITHM_CONTROL_ID, edge_seq};
			edge_addr <= edge_addr + ADDR_WIDTH'(WORD_BYTES);
			edge_seq <= edge_seq + 1'b1;
		end
		// each edge word is a neighbor id
		if (enabled && read_data_valid) begin
			sum <= sum + read_data;
		end
		if (write_go) begin
			write_cmd_addr <= result_base + ADDR_WIDTH'(cur_id * WORD_BYTES);
			write_cmd_data <= sum;
			write_cmd_tag <= {ALGORITHM_CONTROL_ID, cur_id[INDEX_WIDTH-1:0]};
		end
	end

endmodule

/* design/graph_pkg.sv */
package graph_pkg;

	parameter int COUNT_WIDTH = 32;

	// stride of vertex, edge and result arrays
	parameter int WORD_BYTES = 8;

	// one CSR vertex entry, edge offset in the upper half
	typedef struct packed {
		logic [COUNT_WIDTH-1:0] edge_offset;
		logic [COUNT_WIDTH-1:0] degree;
	} vertex_record_t;

	// job is {vertex id, edge offset, degree}
	parameter int JOB_WIDTH = 3 * COUNT_WIDTH;

	typedef enum logic [1:0] {
		V_IDLE,
		V_ISSUE,
		V_DRAIN
	} vertex_state_t;

	typedef enum logic [1:0] {
		A_IDLE,
		A_ISSUE,
		A_COLLECT,
		A_WRITE
	} algorithm_state_t;

endpackage

/* design/sync_fifo.sv */
module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == DEPTH);
	// four or fewer free slots
	assign alfull = (count >= DEPTH - 4);

	// head entry shows while not empty
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* design/vertex_job_control.sv */
module vertex_job_control import cmd_pkg::*, graph_pkg::*; #(
	parameter int VERTEX_QUEUE_DEPTH = 16
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic                   start,
	input  logic [ADDR_WIDTH-1:0]  vertex_base,
	input  logic [COUNT_WIDTH-1:0] num_vertices,
	input  logic                   buffer_alfull,
	input  logic                   read_data_valid,
	input  logic [TAG_WIDTH-1:0]   read_data_tag,
	input  logic [DATA_WIDTH-1:0]  read_data,
	output logic                   cmd_valid,
	output cmd_opcode_t            cmd_opcode,
	output logic [ADDR_WIDTH-1:0]  cmd_addr,
	output logic [TAG_WIDTH-1:0]   cmd_tag,
	input  logic                   job_pop,
	output logic                   job_valid,
	output logic [COUNT_WIDTH-1:0] job_id,
	output logic [COUNT_WIDTH-1:0] job_offset,
	output logic [COUNT_WIDTH-1:0] job_degree,
	output logic [COUNT_WIDTH-1:0] vertices_filtered
);

	// in-flight records stay within the queue's almost-full margin
	localparam int MAX_OUTSTANDING = 4;

	vertex_state_t state;
	logic [COUNT_WIDTH-1:0] issue_index;
	logic [2:0] outstanding;
	logic issue;
	vertex_record_t record;
	logic job_push;
	logic queue_empty;
	logic queue_alfull;
	logic [JOB_WIDTH-1:0] job_in;
	logic [JOB_WIDTH-1:0] job_head;

	assign record = vertex_record_t'(read_data);

	assign issue = enabled && (state == V_ISSUE) && (issue_index != num_vertices) &&
		!buffer_alfull && !queue_alfull && (outstanding < MAX_OUTSTANDING);

	//////////////////////////////
	// record read issue
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= V_IDLE;
			issue_index <= '0;
			outstanding <= '0;
			cmd_valid <= 1'b0;
			vertices_filtered <= '0;
		end else if (enabled) begin
			cmd_valid <= issue;
			outstanding <= outstanding + 3'(issue) - 3'(read_data_valid);
			if (issue) begin
				issue_index <= issue_index + 1'b1;
			end
			if (start) begin
				vertices_filtered <= '0;
			end else if (read_data_valid && record.degree == '0) begin
				vertices_filtered <= vertices_filtered + 1'b1;
			end
			case (state)
				V_IDLE: begin
					if (start) begin
						issue_index <= '0;
						state <= V_ISSUE;
					end
				end
				V_ISSUE: if (issue_index == num_vertices) state <= V_DRAIN;
				// wait for the last records to come back
				V_DRAIN: if (outstanding == '0) state <= V_IDLE;
				default: state <= V_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			cmd_opcode <= READ_CL;
			cmd_addr <= vertex_base + ADDR_WIDTH'(issue_index * WORD_BYTES);
			cmd_tag <= {VERTEX_CONTROL_ID, issue_index[INDEX_WIDTH-1:0]};
		end
	end

	//////////////////////////////
	// vertex job queue
	//////////////////////////////

	// zero degree records are only counted
	assign job_push = enabled && read_data_valid && (record.degree != '0);
	assign job_in = {COUNT_WIDTH'(read_data_tag[INDEX_WIDTH-1:0]), record.edge_offset, record.degree};

	sync_fifo #(
		.WIDTH(JOB_WIDTH),
		.DEPTH(VERTEX_QUEUE_DEPTH)
	) job_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_push),
		.data_in (job_in),
		.pop     (job_pop && enabled),
		.data_out(job_head),
		.empty   (queue_empty),
		.full    (),
		.alfull  (queue_alfull)
	);

	assign job_valid = !queue_empty;
	assign {job_id, job_offset, job_degree} = job_head;

endmodule

/* sim/cu_checker.sv */
module cu_checker #(
	parameter int MAX_VERTICES = 64
) (
	input logic        clock,
	input logic        rstn,
	input logic        read_buffer_alfull,
	input logic        write_buffer_alfull,
	input logic        read_cmd_valid,
	input logic        read_cmd_opcode,
	input logic        write_cmd_valid,
	input logic [31:0] write_cmd_addr,
	input logic [63:0] write_cmd_data,
	input logic [63:0] algorithm_status
);

	// READ_CL is the first opcode
	localparam logic READ_OPCODE = 1'b0;

	string test_name = "reset";
	logic [63:0] exp_sum [MAX_VERTICES];
	bit exp_write [MAX_VERTICES];
	bit got_write [MAX_VERTICES];
	logic [63:0] exp_status;
	logic [31:0] result_base;
	int num_vertices = 0;
	bit running = 1'b0;
	int error_count = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// almost-full levels at the last three clock edges
	logic [2:0] read_hist = 3'b000;
	logic [2:0] write_hist = 3'b000;

	task automatic count_error();
		error_count++;
		test_errors++;
	endtask

	task automatic set_expected(input int v, input logic [63:0] sum, input bit has_write);
		exp_sum[v] = sum;
		exp_write[v] = has_write;
	endtask

	task automatic begin_test(input string name, input int nv, input int ne,
		input logic [31:0] rbase);
		int v;
		test_name = name;
		num_vertices = nv;
		result_base = rbase;
		// edges in the upper half, vertices in the lower half
		exp_status = {32'(ne), 32'(nv)};
		test_errors = 0;
		for (v = 0; v < MAX_VERTICES; v++) begin
			got_write[v] = 1'b0;
			if (v >= nv) begin
				exp_write[v] = 1'b0;
			end
		end
		running = 1'b1;
	endtask

	task automatic check_idle();
		if (read_cmd_valid !== 1'b0 || write_cmd_valid !== 1'b0) begin
			$display("[FAIL] %s valid outputs: expected 00, actual %b%b", test_name,
				read_cmd_valid, write_cmd_valid);
			count_error();
		end
		if (algorithm_status !== 64'd0) begin
			$display("[FAIL] %s status: expected %h, actual %h", test_name, 64'd0,
				algorithm_status);
			count_error();
		end
	endtask

	task automatic check_write();
		logic [31:0] offset;
		int v;
		offset = write_cmd_addr - result_base;
		v = int'(offset >> 3);
		if (!running || offset[2:0] != 3'b000 || v >= num_vertices || !exp_write[v] ||
			got_write[v]) begin
			$display("%s: unexpected write to address %h", test_name, write_cmd_addr);
			count_error();
		end else begin
			got_write[v] = 1'b1;
			if (write_cmd_data !== exp_sum[v]) begin
				$display("[FAIL] %s vertex %0d: expected %h, actual %h", test_name, v,
					exp_sum[v], write_cmd_data);
				count_error();
			end
		end
	endtask

	task automatic end_test();
		int v;
		if (algorithm_status !== exp_status) begin
			$display("[FAIL] %s status: expected %h, actual %h", test_name, exp_status,
				algorithm_status);
			count_error();
		end
		for (v = 0; v < num_vertices; v++) begin
			if (exp_write[v] && !got_write[v]) begin
				$display("%s: no result write was seen for vertex %0d", test_name, v);
				count_error();
			end
		end
		running = 1'b0;
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, test_errors);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("%s: timed out waiting for %s", test_name, what);
		count_error();
		running = 1'b0;
		tests_run++;
		tests_failed++;
	endtask

	task automatic print_counts();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
	endtask

	//////////////////////////////
	// port monitor
	//////////////////////////////

	// a command at the pins was granted against the level three edges back
	always @(posedge clock) begin : watch
		if (rstn) begin
			if (read_cmd_valid === 1'b1 && read_hist[2]) begin
				$display("%s: read command issued while read_buffer_alfull was high",
					test_name);
				count_error();
			end
			if (read_cmd_valid === 1'b1 && read_cmd_opcode !== READ_OPCODE) begin
				$display("[FAIL] %s read opcode: expected %b, actual %b", test_name,
					READ_OPCODE, read_cmd_opcode);
				count_error();
			end
			if (write_cmd_valid === 1'b1 && write_hist[2]) begin
				$display("%s: write command issued while write_buffer_alfull was high",
					test_name);
				count_error();
			end
			if (write_cmd_valid === 1'b1) begin
				check_write();
			end
		end
		read_hist = {read_hist[1:0], read_buffer_alfull};
		write_hist = {write_hist[1:0], write_buffer_alfull};
	end

endmodule

/* sim/tb_cu_control.sv */
module tb_cu_control;

	localparam int MAX_VERTICES = 64;
	localparam int MAX_EDGES = 512;
	localparam int MAX_TESTS = 8;
	localparam int POOL_SIZE = 64;
	localparam logic [31:0] VERTEX_BASE = 32'h0000_1000;
	localparam logic [31:0] EDGE_BASE = 32'h0000_4000;
	localparam logic [31:0] RESULT_BASE = 32'h0000_8000;

	logic clock;
	logic rstn;
	logic enabled;
	logic start;
	logic [31:0] vertex_base;
	logic [31:0] edge_base;
	logic [31:0] result_base;
	logic [31:0] num_vertices;
	logic [31:0] num_edges;
	logic read_cmd_valid;
	logic read_cmd_opcode;
	logic [31:0] read_cmd_addr;
	logic [15:0] read_cmd_tag;
	logic read_buffer_alfull;
	logic read_data_valid;
	logic [15:0] read_data_tag;
	logic [63:0] read_data;
	logic write_cmd_valid;
	logic [31:0] write_cmd_addr;
	logic [63:0] write_cmd_data;
	logic [15:0] write_cmd_tag;
	logic write_buffer_alfull;
	logic write_resp_valid;
	logic [15:0] write_resp_tag;
	logic [63:0] algorithm_status;

	// test table
	string test_name [MAX_TESTS];
	int test_vertices [MAX_TESTS];
	int test_max_degree [MAX_TESTS];
	int test_mode [MAX_TESTS];
	int num_tests = 0;

	// memory model
	logic [63:0] vertex_mem [MAX_VERTICES];
	logic [63:0] edge_mem [MAX_EDGES];
	logic [31:0] read_addr_pool [POOL_SIZE];
	logic [15:0] read_tag_pool [POOL_SIZE];
	int read_count = 0;
	logic [15:0] write_tag_pool [POOL_SIZE];
	int write_count = 0;
	// bit 0 toggles the read level, bit 1 the write level
	int pressure_mode = 0;
	integer seed = 32'h09742eb6;
	bit timed_out = 1'b0;

	initial begin
		clock = 1'b0;
	end

	always #5 clock = ~clock;

	cu_control #(
		.VERTEX_QUEUE_DEPTH(16),
		.COMMAND_BUFFER_DEPTH(8)
	) dut0 (.*);

	cu_checker #(
		.MAX_VERTICES(MAX_VERTICES)
	) checker0 (
		.clock              (clock),
		.rstn               (rstn),
		.read_buffer_alfull (read_buffer_alfull),
		.write_buffer_alfull(write_buffer_alfull),
		.read_cmd_valid     (read_cmd_valid),
		.read_cmd_opcode    (read_cmd_opcode),
		.write_cmd_valid    (write_cmd_valid),
		.write_cmd_addr     (write_cmd_addr),
		.write_cmd_data     (write_cmd_data),
		.algorithm_status   (algorithm_status)
	);

	task automatic add_test(input string name, input int vertices, input int max_degree,
		input int mode);
		test_name[num_tests] = name;
		test_vertices[num_tests] = vertices;
		test_max_degree[num_tests] = max_degree;
		test_mode[num_tests] = mode;
		num_tests++;
	endtask

	//////////////////////////////
	// memory model
	//////////////////////////////

	function automatic logic [63:0] read_word(input logic [31:0] addr);
		if (addr >= VERTEX_BASE && addr < VERTEX_BASE + 32'(8 * MAX_VERTICES)) begin
			return vertex_mem[(addr - VERTEX_BASE) >> 3];
		end
		if (addr >= EDGE_BASE && addr < EDGE_BASE + 32'(8 * MAX_EDGES)) begin
			return edge_mem[(addr - EDGE_BASE) >> 3];
		end
		// unmapped space
		return {~addr, addr};
	endfunction

	always @(posedge clock) begin
		if (read_cmd_valid === 1'b1) begin
			read_addr_pool[read_count] = read_cmd_addr;
			read_tag_pool[read_count] = read_cmd_tag;
			read_count++;
		end
		if (write_cmd_valid === 1'b1) begin
			write_tag_pool[write_count] = write_cmd_tag;
			write_count++;
		end
	end

	// answers come in random order after random delays
	always @(negedge clock) begin : respond
		int pick;
		read_data_valid = 1'b0;
		write_resp_valid = 1'b0;
		if (read_count > 0 && ($random(seed) & 1)) begin
			pick = $unsigned($random(seed)) % read_count;
			read_data_valid = 1'b1;
			read_data_tag = read_tag_pool[pick];
			read_data = read_word(read_addr_pool[pick]);
			read_count--;
			read_addr_pool[pick] = read_addr_pool[read_count];
			read_tag_pool[pick] = read_tag_pool[read_count];
		end
		if (write_count > 0 && ($random(seed) & 1)) begin
			pick = $unsigned($random(seed)) % write_count;
			write_resp_valid = 1'b1;
			write_resp_tag = write_tag_pool[pick];
			write_count--;
			write_tag_pool[pick] = write_tag_pool[write_count];
		end
		read_buffer_alfull = pressure_mode[0] && ($random(seed) & 1);
		write_buffer_alfull = pressure_mode[1] && ($random(seed) & 1);
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	task automatic run_test(input int t);
		int nv;
		int offset;
		int degree;
		int neighbor;
		int v;
		int e;
		int cycles;
		logic [63:0] sum;
		nv = test_vertices[t];
		offset = 0;
		@(posedge clock);
		// CSR arrays and the neighbor sums
		for (v = 0; v < nv; v++) begin
			degree = 0;
			if (test_max_degree[t] != 0) begin
				degree = $unsigned($random(seed)) % (test_max_degree[t] + 1);
			end
			vertex_mem[v] = {32'(offset), 32'(degree)};
			sum = '0;
			for (e = 0; e < degree; e++) begin
				neighbor = $unsigned($random(seed)) % nv;
				edge_mem[offset + e] = 64'(neighbor);
				sum += 64'(neighbor);
			end
			checker0.set_expected(v, sum, degree != 0);
			offset += degree;
		end
		checker0.begin_test(test_name[t], nv, offset, RESULT_BASE);
		pressure_mode = test_mode[t];
		@(negedge clock);
		num_vertices = 32'(nv);
		num_edges = 32'(offset);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		// old status drops once the counters clear
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (algorithm_status !== 64'd0 && cycles < 100);
		if (algorithm_status !== 64'd0) begin
			checker0.report_timeout("the status word to clear after start");
			timed_out = 1'b1;
		end else begin
			cycles = 0;
			do begin
				@(posedge clock);
				cycles++;
			end while (algorithm_status === 64'd0 && cycles < 20000);
			if (algorithm_status === 64'd0) begin
				checker0.report_timeout("a non-zero status word");
				timed_out = 1'b1;
			end else begin
				checker0.end_test();
			end
		end
		pressure_mode = 0;
	endtask

	initial begin
		rstn = 1'b0;
		enabled = 1'b1;
		start = 1'b0;
		vertex_base = VERTEX_BASE;
		edge_base = EDGE_BASE;
		result_base = RESULT_BASE;
		num_vertices = '0;
		num_edges = '0;
		read_buffer_alfull = 1'b0;
		read_data_valid = 1'b0;
		read_data_tag = '0;
		read_data = '0;
		write_buffer_alfull = 1'b0;
		write_resp_valid = 1'b0;
		write_resp_tag = '0;
		add_test("basic", 8, 3, 0);
		add_test("sparse", 16, 1, 0);
		add_test("zero_degree", 6, 0, 0);
		add_test("read_pressure", 24, 4, 1);
		add_test("write_pressure", 24, 4, 2);
		add_test("mixed_pressure", 40, 6, 3);
		repeat (4) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		@(posedge clock);
		checker0.check_idle();
		for (int t = 0; t < num_tests && !timed_out; t++) begin
			run_test(t);
		end
		checker0.print_counts();
		if (checker0.error_count == 0 && !timed_out) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* verilog.f */
design/cmd_pkg.sv
design/graph_pkg.sv
design/sync_fifo.sv
design/command_arbiter.sv
design/vertex_job_control.sv
design/graph_algorithm_control.sv
design/cu_control.sv
sim/cu_checker.sv
sim/tb_cu_control.sv
